/* common/panel_geometry_pkg.sv */
// panel geometry and pixel format for a 16x8 panel scanned as two halves
// the framebuffer holds one word per (row, column) of a half, top and bottom pixels side by side
package panel_geometry_pkg;

    localparam int PIXEL_WIDTH       = 16;
    localparam int PIXEL_HALFHEIGHT  = 4;
    localparam int PIXEL_HEIGHT      = 8;
    localparam int BRIGHTNESS_LEVELS = 4;   // bits per channel, also number of planes

    localparam int ROW_BITS   = 2;
    localparam int COL_BITS   = 4;
    localparam int PLANE_BITS = 2;

    // word index is row * PIXEL_WIDTH + column
    localparam int WORD_ADDR_BITS = 6;
    localparam int LANE_BITS      = 2;
    localparam int BYTE_ADDR_BITS = 8;      // lane on top of the word index
    localparam int LANES          = 4;
    localparam int FB_WORDS       = PIXEL_WIDTH * PIXEL_HALFHEIGHT;

    // field positions inside pixel_t
    localparam int RED_LSB   = 8;
    localparam int GREEN_LSB = 4;
    localparam int BLUE_LSB  = 0;

    // bit positions inside rgb_t
    localparam int RGB_RED   = 0;
    localparam int RGB_GREEN = 1;
    localparam int RGB_BLUE  = 2;

    typedef logic [15:0] pixel_t;           // [15:12] unused, r [11:8], g [7:4], b [3:0]

    // lane 0 top low byte, lane 1 top high byte, lane 2/3 same for bottom
    typedef logic [31:0] fb_word_t;

    typedef logic [BRIGHTNESS_LEVELS-1:0] brightness_mask_t;

    typedef logic [2:0] rgb_t;

endpackage

/* common/panel_cmd_pkg.sv */
// command opcodes and the FSM state encodings for parser and scan engine
// opcodes are plain ASCII letters, arguments follow as raw bytes
package panel_cmd_pkg;

    // P x y hi lo | R en | B mask
    typedef enum logic [7:0] {
        CMD_PIXEL      = 8'h50,
        CMD_RGB_ENABLE = 8'h52,
        CMD_BRIGHTNESS = 8'h42
    } cmd_opcode_t;

    typedef enum logic [2:0] {
        IDLE,
        GET_X,
        GET_Y,
        GET_HI,
        GET_LO,
        GET_ARG     // single argument byte of R or B
    } parse_state_t;

    // two shift states per column, then latch, then lit
    typedef enum logic [1:0] {
        SHIFT_LOW,
        SHIFT_HIGH,
        LATCH,
        DISPLAY
    } scan_state_t;

endpackage

/* command/command_parser.sv */
// byte command decoder: P x y hi lo writes a pixel, R sets channel enables, B sets plane enables
// out of range pixels are consumed without a write, unknown opcodes are dropped
`timescale 1ns/1ps

module command_parser (
    input  logic                                           clk_root,
    input  logic                                           rst_n,
    input  logic [7:0]                                     rx_data,
    input  logic                                           rx_valid,
    output logic                                           ram_wr_en,
    output logic [panel_geometry_pkg::BYTE_ADDR_BITS-1:0]  ram_wr_addr,
    output logic [7:0]                                     ram_wr_data,
    output panel_geometry_pkg::rgb_t                       rgb_enable,
    output panel_geometry_pkg::brightness_mask_t           brightness_enable
);
    import panel_geometry_pkg::*;
    import panel_cmd_pkg::*;

    parse_state_t state;
    cmd_opcode_t  arg_op;       // which enable GET_ARG updates
    logic [7:0]   x_reg;
    logic [7:0]   y_reg;

    logic                      in_range;
    logic                      bottom_half;
    logic [WORD_ADDR_BITS-1:0] word_idx;
    logic [LANE_BITS-1:0]      lane;

    assign in_range    = (x_reg < 8'(PIXEL_WIDTH)) && (y_reg < 8'(PIXEL_HEIGHT));
    assign bottom_half = (y_reg >= 8'(PIXEL_HALFHEIGHT));
    // y mod half height, half height is a power of two
    assign word_idx    = {y_reg[ROW_BITS-1:0], x_reg[COL_BITS-1:0]};
    assign lane        = {bottom_half, state == GET_HI};   // high byte first

    always_ff @(posedge clk_root or negedge rst_n) begin
        if (!rst_n) begin
            state             <= IDLE;
            arg_op            <= CMD_RGB_ENABLE;
            ram_wr_en         <= 1'b0;
            rgb_enable        <= '1;
            brightness_enable <= '1;
        end else begin
            ram_wr_en <= 1'b0;  // single cycle pulse
            if (rx_valid) begin
                case (state)
                    IDLE: begin
                        case (rx_data)
                            CMD_PIXEL: state <= GET_X;
                            CMD_RGB_ENABLE, CMD_BRIGHTNESS: begin
                                arg_op <= cmd_opcode_t'(rx_data);
                                state  <= GET_ARG;
                            end
                            default: state <= IDLE;     // unknown, drop
                        endcase
                    end
                    GET_X: state <= GET_Y;
                    GET_Y: state <= GET_HI;
                    GET_HI: begin
                        ram_wr_en <= in_range;
                        state     <= GET_LO;
                    end
                    GET_LO: begin
                        ram_wr_en <= in_range;
                        state     <= IDLE;
                    end
                    GET_ARG: begin
                        if (arg_op == CMD_RGB_ENABLE) begin
                            rgb_enable <= rx_data[2:0];
                        end else begin
                            brightness_enable <= rx_data[BRIGHTNESS_LEVELS-1:0];
                        end
                        state <= IDLE;
                    end
                    default: state <= IDLE;
                endcase
            end
        end
    end

    // coordinates and write payload
    always_ff @(posedge clk_root) begin
        if (rx_valid) begin
            if (state == GET_X) begin
                x_reg <= rx_data;
            end
            if (state == GET_Y) begin
                y_reg <= rx_data;
            end
            ram_wr_data <= rx_data;
            ram_wr_addr <= {lane, word_idx};    // only used with ram_wr_en
        end
    end

endmodule

/* framebuffer/frame_ram.sv */
// framebuffer of four byte lanes, byte write port and full word read port
// read latency is one cycle, a read and a write to the same word return the old data
// contents are not cleared by reset
`timescale 1ns/1ps

module frame_ram (
    input  logic                                           clk_root,
    input  logic                                           wr_en,
    input  logic [panel_geometry_pkg::BYTE_ADDR_BITS-1:0]  wr_addr,
    input  logic [7:0]                                     wr_data,
    input  logic [panel_geometry_pkg::WORD_ADDR_BITS-1:0]  rd_addr,
    output panel_geometry_pkg::fb_word_t                   rd_data
);
    import panel_geometry_pkg::*;

    logic [7:0] mem [LANES][FB_WORDS];

    logic [LANE_BITS-1:0]      wr_lane;
    logic [WORD_ADDR_BITS-1:0] wr_word;

    // lane sits above the word index
    assign wr_lane = wr_addr[BYTE_ADDR_BITS-1 -: LANE_BITS];
    assign wr_word = wr_addr[WORD_ADDR_BITS-1:0];

    always_ff @(posedge clk_root) begin
        if (wr_en) begin
            mem[wr_lane][wr_word] <= wr_data;
        end
    end

    // all lanes of one word, lane 0 in the low byte
    always_ff @(posedge clk_root) begin
        for (int l = 0; l < LANES; l++) begin
            rd_data[l*8 +: 8] <= mem[l][rd_addr];
        end
    end

endmodule

/* scan/scan_sequencer.sv */
// scan timing for the panel, one state step per tick of SCAN_DIVIDE clk_root cycles
// per row and plane: 16 columns of low/high shift ticks, one latch tick,
// then OE_BASE_TICKS << plane lit ticks; SCAN_DIVIDE must be 3 or more
`timescale 1ns/1ps

module scan_sequencer #(
    parameter int SCAN_DIVIDE   = 4,
    parameter int OE_BASE_TICKS = 2
) (
    input  logic                                           clk_root,
    input  logic                                           rst_n,
    output logic [panel_geometry_pkg::WORD_ADDR_BITS-1:0]  fetch_addr,
    output logic [panel_geometry_pkg::PLANE_BITS-1:0]      fetch_plane,
    output logic                                           fetch_strobe,
    output logic [panel_geometry_pkg::ROW_BITS-1:0]        row_address,
    output logic                                           clk_pixel,
    output logic                                           row_latch,
    output logic                                           oe_n
);
    import panel_geometry_pkg::*;
    import panel_cmd_pkg::*;

    localparam int DIV_BITS  = $clog2(SCAN_DIVIDE);
    // wide enough for the longest plane
    localparam int DISP_BITS = $clog2(OE_BASE_TICKS << (BRIGHTNESS_LEVELS - 1)) + 1;

    logic [DIV_BITS-1:0]   div_cnt;
    logic                  tick;

    scan_state_t           state;
    logic [COL_BITS-1:0]   col;
    logic [PLANE_BITS-1:0] plane;
    logic [ROW_BITS-1:0]   row;
    logic [DISP_BITS-1:0]  disp_cnt;
    logic [DISP_BITS-1:0]  disp_len;

    assign tick     = (div_cnt == DIV_BITS'(SCAN_DIVIDE - 1));
    assign disp_len = DISP_BITS'(OE_BASE_TICKS) << plane;   // binary weighted

    always_ff @(posedge clk_root or negedge rst_n) begin
        if (!rst_n) begin
            div_cnt <= '0;
        end else if (tick) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk_root or negedge rst_n) begin
        if (!rst_n) begin
            state       <= SHIFT_LOW;
            col         <= '0;
            plane       <= '0;
            row         <= '0;
            disp_cnt    <= '0;
            row_address <= '0;
        end else if (tick) begin
            case (state)
                SHIFT_LOW: state <= SHIFT_HIGH;
                SHIFT_HIGH: begin
                    if (col == COL_BITS'(PIXEL_WIDTH - 1)) begin
                        col         <= '0;
                        row_address <= row;     // row just shifted in
                        state       <= LATCH;
                    end else begin
                        col   <= col + 1'b1;
                        state <= SHIFT_LOW;
                    end
                end
                LATCH: begin
                    disp_cnt <= '0;
                    state    <= DISPLAY;
                end
                DISPLAY: begin
                    if (disp_cnt == disp_len - DISP_BITS'(1)) begin
                        disp_cnt <= '0;
                        state    <= SHIFT_LOW;
                        // planes inside a row, then next row
                        if (plane == PLANE_BITS'(BRIGHTNESS_LEVELS - 1)) begin
                            plane <= '0;
                            row   <= row + 1'b1;
                        end else begin
                            plane <= plane + 1'b1;
                        end
                    end else begin
                        disp_cnt <= disp_cnt + 1'b1;
                    end
                end
                default: state <= SHIFT_LOW;
            endcase
        end
    end

    assign fetch_addr   = {row, col};
    assign fetch_plane  = plane;
    assign fetch_strobe = (state == SHIFT_LOW) && (div_cnt == '0);  // first cycle only

    // decoded from the state register
    assign clk_pixel = (state == SHIFT_HIGH);
    assign row_latch = (state == LATCH);
    assign oe_n      = (state != DISPLAY);

endmodule

/* scan/pixel_fetch.sv */
// reads the framebuffer word for a column and produces the plane bit of each channel
// outputs are valid two cycles after fetch_strobe and hold until the next fetch
`timescale 1ns/1ps

module pixel_fetch (
    input  logic                                           clk_root,
    input  logic                                           rst_n,
    input  logic                                           fetch_strobe,
    input  logic [panel_geometry_pkg::WORD_ADDR_BITS-1:0]  fetch_addr,
    input  logic [panel_geometry_pkg::PLANE_BITS-1:0]      fetch_plane,
    input  panel_geometry_pkg::rgb_t                       rgb_enable,
    input  panel_geometry_pkg::brightness_mask_t           brightness_enable,
    input  panel_geometry_pkg::fb_word_t                   rd_data,
    output logic [panel_geometry_pkg::WORD_ADDR_BITS-1:0]  rd_addr,
    output panel_geometry_pkg::rgb_t                       rgb1,
    output panel_geometry_pkg::rgb_t                       rgb2
);
    import panel_geometry_pkg::*;

    logic   strobe_d;   // rd_data valid this cycle
    pixel_t top_pix;
    pixel_t bot_pix;
    rgb_t   plane_mask;

    // pick one brightness bit from each channel
    function automatic rgb_t plane_bits(input pixel_t pix, input logic [PLANE_BITS-1:0] p);
        rgb_t bits;
        bits[RGB_RED]   = pix[RED_LSB + p];
        bits[RGB_GREEN] = pix[GREEN_LSB + p];
        bits[RGB_BLUE]  = pix[BLUE_LSB + p];
        return bits;
    endfunction

    assign rd_addr              = fetch_addr;
    assign {bot_pix, top_pix}   = rd_data;      // lanes 0/1 top, 2/3 bottom
    assign plane_mask           = rgb_enable & {3{brightness_enable[fetch_plane]}};

    always_ff @(posedge clk_root or negedge rst_n) begin
        if (!rst_n) begin
            strobe_d <= 1'b0;
            rgb1     <= '0;
            rgb2     <= '0;
        end else begin
            strobe_d <= fetch_strobe;
            if (strobe_d) begin
                rgb1 <= plane_bits(top_pix, fetch_plane) & plane_mask;
                rgb2 <= plane_bits(bot_pix, fetch_plane) & plane_mask;
            end
        end
    end

endmodule

/* verilog/led_matrix_top.sv */
// LED panel controller, everything on clk_root
// rx_data/rx_valid must already be in the clk_root domain, no back-pressure
// SCAN_DIVIDE must be at least 3 so fetched pixels settle before the shift clock
`timescale 1ns/1ps

module led_matrix_top #(
    parameter int SCAN_DIVIDE   = 4,
    parameter int OE_BASE_TICKS = 2
) (
    input  logic                                     clk_root,
    input  logic                                     rst_n,
    input  logic [7:0]                               rx_data,
    input  logic                                     rx_valid,
    output panel_geometry_pkg::rgb_t                 rgb1,
    output panel_geometry_pkg::rgb_t                 rgb2,
    output logic [panel_geometry_pkg::ROW_BITS-1:0]  row_address,
    output logic                                     clk_pixel,
    output logic                                     row_latch,
    output logic                                     oe_n
);
    import panel_geometry_pkg::*;

    logic                      ram_wr_en;
    logic [BYTE_ADDR_BITS-1:0] ram_wr_addr;
    logic [7:0]                ram_wr_data;
    logic [WORD_ADDR_BITS-1:0] rd_addr;
    fb_word_t                  rd_data;

    rgb_t                      rgb_enable;
    brightness_mask_t          brightness_enable;

    logic [WORD_ADDR_BITS-1:0] fetch_addr;
    logic [PLANE_BITS-1:0]     fetch_plane;
    logic                      fetch_strobe;

    command_parser parser_i (
        .clk_root          (clk_root),
        .rst_n             (rst_n),
        .rx_data           (rx_data),
        .rx_valid          (rx_valid),
        .ram_wr_en         (ram_wr_en),
        .ram_wr_addr       (ram_wr_addr),
        .ram_wr_data       (ram_wr_data),
        .rgb_enable        (rgb_enable),
        .brightness_enable (brightness_enable)
    );

    frame_ram fb_i (
        .clk_root (clk_root),
        .wr_en    (ram_wr_en),
        .wr_addr  (ram_wr_addr),
        .wr_data  (ram_wr_data),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data)
    );

    scan_sequencer #(
        .SCAN_DIVIDE   (SCAN_DIVIDE),
        .OE_BASE_TICKS (OE_BASE_TICKS)
    ) scan_i (
        .clk_root     (clk_root),
        .rst_n        (rst_n),
        .fetch_addr   (fetch_addr),
        .fetch_plane  (fetch_plane),
        .fetch_strobe (fetch_strobe),
        .row_address  (row_address),
        .clk_pixel    (clk_pixel),
        .row_latch    (row_latch),
        .oe_n         (oe_n)
    );

    pixel_fetch fetch_i (
        .clk_root          (clk_root),
        .rst_n             (rst_n),
        .fetch_strobe      (fetch_strobe),
        .fetch_addr        (fetch_addr),
        .fetch_plane       (fetch_plane),
        .rgb_enable        (rgb_enable),
        .brightness_enable (brightness_enable),
        .rd_data           (rd_data),
        .rd_addr           (rd_addr),
        .rgb1              (rgb1),
        .rgb2              (rgb2)
    );

endmodule

/* verification/led_matrix_tb.sv */
// testbench for led_matrix_top with a model framebuffer and a panel monitor
// the first table group writes every pixel, since the framebuffer powers up unknown
`timescale 1ns/1ps

module led_matrix_tb;
    import panel_geometry_pkg::*;

    localparam int SCAN_DIVIDE   = 4;
    localparam int OE_BASE_TICKS = 2;
    localparam int MAX_ENTRIES   = 140;
    localparam int N_GROUPS      = 4;
    localparam int N_FRAMES      = 3 * N_GROUPS;   // table, alignment and checked frame per group
    localparam int BYTE_GAP      = 3;

    localparam logic [7:0] OP_PIXEL  = "P";
    localparam logic [7:0] OP_RGB_EN = "R";
    localparam logic [7:0] OP_BRIGHT = "B";
    localparam logic [7:0] OP_BOGUS  = "Z";

    logic       clk_root;
    logic       rst_n;
    logic [7:0] rx_data;
    logic       rx_valid;
    rgb_t       rgb1;
    rgb_t       rgb2;
    logic [1:0] row_address;
    logic       clk_pixel;
    logic       row_latch;
    logic       oe_n;

    // stimulus table
    int          tbl_grp [MAX_ENTRIES];
    logic [7:0]  tbl_op  [MAX_ENTRIES];
    logic [7:0]  tbl_x   [MAX_ENTRIES];
    logic [7:0]  tbl_y   [MAX_ENTRIES];
    logic [15:0] tbl_val [MAX_ENTRIES];
    int          n_entries;

    logic [15:0] model_fb [PIXEL_HEIGHT][PIXEL_WIDTH];
    logic [2:0]  model_rgb_en;
    logic [3:0]  model_bright;

    int   seed;
    int   cycle_cnt;
    int   timeout_limit;
    logic check_en;
    int   latch_cnt;    // latches since reset
    int   pix_cnt;      // pixel clocks since last latch
    int   oe_low_cnt;
    logic clk_pixel_q;
    logic latch_q;
    logic oe_q;

    led_matrix_top #(
        .SCAN_DIVIDE   (SCAN_DIVIDE),
        .OE_BASE_TICKS (OE_BASE_TICKS)
    ) dut_i (
        .clk_root    (clk_root),
        .rst_n       (rst_n),
        .rx_data     (rx_data),
        .rx_valid    (rx_valid),
        .rgb1        (rgb1),
        .rgb2        (rgb2),
        .row_address (row_address),
        .clk_pixel   (clk_pixel),
        .row_latch   (row_latch),
        .oe_n        (oe_n)
    );

    initial clk_root = 1'b0;
    always #20 clk_root = ~clk_root;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("Fail %s: got 0x%h, expected 0x%h", name, got, expected);
            $display("Something failed");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    function automatic int frame_cycles();
        int ticks;
        ticks = 0;
        for (int p = 0; p < BRIGHTNESS_LEVELS; p++) begin
            ticks += 2 * PIXEL_WIDTH + 1 + (OE_BASE_TICKS << p);
        end
        return PIXEL_HALFHEIGHT * ticks * SCAN_DIVIDE;
    endfunction

    // plane bit of r, g, b after channel and plane enables
    function automatic logic [2:0] expected_rgb(input logic [15:0] pix, input int plane);
        logic [2:0] bits;
        bits[0] = pix[8 + plane];
        bits[1] = pix[4 + plane];
        bits[2] = pix[plane];
        return bits & model_rgb_en & {3{model_bright[plane]}};
    endfunction

    task automatic add_entry(input int grp, input logic [7:0] op, input logic [7:0] x,
                             input logic [7:0] y, input logic [15:0] val);
        tbl_grp[n_entries] = grp;
        tbl_op[n_entries]  = op;
        tbl_x[n_entries]   = x;
        tbl_y[n_entries]   = y;
        tbl_val[n_entries] = val;
        n_entries++;
    endtask

    task automatic fill_table();
        n_entries = 0;
        for (int y = 0; y < PIXEL_HEIGHT; y++) begin
            for (int x = 0; x < PIXEL_WIDTH; x++) begin
                add_entry(0, OP_PIXEL, 8'(x), 8'(y), 16'($random(seed)));
            end
        end
        add_entry(1, OP_RGB_EN, 8'd0, 8'd0, 16'd5);     // green off
        for (int k = 0; k < 4; k++) begin
            add_entry(1, OP_PIXEL, 8'($random(seed) & 15), 8'($random(seed) & 7),
                      16'($random(seed)));
        end
        add_entry(2, OP_RGB_EN, 8'd0, 8'd0, 16'd7);
        add_entry(2, OP_BRIGHT, 8'd0, 8'd0, 16'd5);     // planes 1 and 3 dark
        add_entry(3, OP_BRIGHT, 8'd0, 8'd0, 16'd15);
        add_entry(3, OP_PIXEL, 8'd20, 8'd3, 16'($random(seed)));
        add_entry(3, OP_BOGUS, 8'd0, 8'd0, 16'd0);
        add_entry(3, OP_PIXEL, 8'd5, 8'd6, 16'($random(seed)));
    endtask

    // starts and ends 1 ns after a rising edge
    task automatic send_byte(input logic [7:0] b);
        rx_data  = b;
        rx_valid = 1'b1;
        @(posedge clk_root);
        #1;
        rx_valid = 1'b0;
        repeat (BYTE_GAP) @(posedge clk_root);
        #1;
    endtask

    task automatic apply_entry(input int i);
        if (tbl_op[i] == OP_PIXEL) begin
            send_byte(OP_PIXEL);
            send_byte(tbl_x[i]);
            send_byte(tbl_y[i]);
            send_byte(tbl_val[i][15:8]);
            send_byte(tbl_val[i][7:0]);
            if (tbl_x[i] < 8'(PIXEL_WIDTH) && tbl_y[i] < 8'(PIXEL_HEIGHT)) begin
                model_fb[tbl_y[i][2:0]][tbl_x[i][3:0]] = tbl_val[i];
            end
        end else if (tbl_op[i] == OP_RGB_EN) begin
            send_byte(OP_RGB_EN);
            send_byte(tbl_val[i][7:0]);
            model_rgb_en = tbl_val[i][2:0];
        end else if (tbl_op[i] == OP_BRIGHT) begin
            send_byte(OP_BRIGHT);
            send_byte(tbl_val[i][7:0]);
            model_bright = tbl_val[i][3:0];
        end else begin
            send_byte(tbl_op[i]);   // parser drops it
        end
    endtask

    task automatic wait_frame_boundary();
        int start;
        start = latch_cnt;
        @(posedge clk_root);
        while (latch_cnt == start || latch_cnt % 16 != 0) begin
            @(posedge clk_root);
        end
        #1;
    endtask

    task automatic check_column();
        int row;
        int plane;
        row   = (latch_cnt / 4) % 4;
        plane = latch_cnt % 4;
        check_value("rgb1", 32'(rgb1), 32'(expected_rgb(model_fb[row][pix_cnt], plane)));
        check_value("rgb2", 32'(rgb2), 32'(expected_rgb(model_fb[row + 4][pix_cnt], plane)));
    endtask

    // panel model on the falling edge
    always @(negedge clk_root) begin
        if (!rst_n) begin
            latch_cnt   = 0;
            pix_cnt     = 0;
            oe_low_cnt  = 0;
            clk_pixel_q = 1'b0;
            latch_q     = 1'b0;
            oe_q        = 1'b1;
        end else begin
            if (clk_pixel || row_latch) begin
                check_value("oe_n", 32'(oe_n), 32'd1);
            end
            if (clk_pixel && !clk_pixel_q) begin
                if (check_en) begin
                    check_column();
                end
                pix_cnt++;
            end
            if (row_latch && !latch_q) begin
                check_value("clk_pixel count", 32'(pix_cnt), 32'(PIXEL_WIDTH));
                latch_cnt++;
                pix_cnt = 0;
            end
            if (!oe_n) begin
                check_value("row_address", 32'(row_address), 32'(((latch_cnt - 1) / 4) % 4));
                oe_low_cnt++;
            end else if (!oe_q) begin
                check_value("oe_n low cycles", 32'(oe_low_cnt),
                            32'((OE_BASE_TICKS << ((latch_cnt - 1) % 4)) * SCAN_DIVIDE));
                oe_low_cnt = 0;
            end
            clk_pixel_q = clk_pixel;
            latch_q     = row_latch;
            oe_q        = oe_n;
        end
    end

    always @(posedge clk_root) begin
        cycle_cnt++;
        if (cycle_cnt >= timeout_limit) begin
            $display("Timeout: the scan did not finish the checked frames in %0d cycles",
                     timeout_limit);
            $display("Something failed");
            $fatal(1, "timeout");
        end
    end

    initial begin
        rst_n         = 1'b0;
        rx_data       = 8'h00;
        rx_valid      = 1'b0;
        check_en      = 1'b0;
        seed          = 5;
        cycle_cnt     = 0;
        timeout_limit = frame_cycles() * N_FRAMES * 2;
        model_rgb_en  = 3'b111;
        model_bright  = 4'b1111;
        for (int y = 0; y < PIXEL_HEIGHT; y++) begin
            for (int x = 0; x < PIXEL_WIDTH; x++) begin
                model_fb[y][x] = 16'h0000;
            end
        end
        fill_table();
        repeat (5) @(posedge clk_root);
        #1;
        rst_n = 1'b1;

        for (int g = 0; g < N_GROUPS; g++) begin
            check_en = 1'b0;
            for (int i = 0; i < n_entries; i++) begin
                if (tbl_grp[i] == g) begin
                    apply_entry(i);
                end
            end
            wait_frame_boundary();
            check_en = 1'b1;    // one full frame against the model
            wait_frame_boundary();
            check_en = 1'b0;
        end
        $display("Everything OK");
        $finish;
    end

endmodule

/* flist.f */
common/panel_geometry_pkg.sv
common/panel_cmd_pkg.sv
command/command_parser.sv
framebuffer/frame_ram.sv
scan/scan_sequencer.sv
scan/pixel_fetch.sv
verilog/led_matrix_top.sv
verification/led_matrix_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the LED matrix testbench, result taken from the simulation log
rm -rf obj_dir build.log sim.log
verilator --binary --timing --top-module led_matrix_tb -f flist.f -o led_matrix_sim > build.log 2>&1 \
    && ./obj_dir/led_matrix_sim > sim.log 2>&1 \
    && grep -q "Everything OK" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see build.log and sim.log"; exit 1; }
